/* Makefile */
# Verilator build and run of the 1x1 conv layer testbench

VERILATOR ?= verilator
TOP       ?= conv1x1_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

# Build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* dv/conv1x1_sva.sv */
`timescale 1ns/10ps
`default_nettype none

`include "conv1x1_config.svh"

module conv1x1_sva (
  input logic clk,
  input logic reset,
  input logic valid_in,
  input logic valid_out
);

  localparam int C_IN  = `CONV_C_IN;
  localparam int C_OUT = `CONV_C_OUT;

  int   chan_seen;
  int   run_len;
  logic last_in;
  // Number of failed properties so far
  int   err_count = 0;

  //////////////////////////////
  // Local trackers
  //////////////////////////////

  // Own channel count of the input stream
  always_ff @(posedge clk) begin
    if (reset) begin
      chan_seen <= 0;
    end else if (valid_in) begin
      chan_seen <= (chan_seen == C_IN - 1) ? 0 : chan_seen + 1;
    end
  end

  // Final channel of a pixel being sampled
  assign last_in = valid_in && (chan_seen == C_IN - 1);

  // Length of the current valid_out run
  always_ff @(posedge clk) begin
    if (reset) begin
      run_len <= 0;
    end else if (valid_out) begin
      run_len <= run_len + 1;
    end else begin
      run_len <= 0;
    end
  end

  //////////////////////////////
  // Properties
  //////////////////////////////

  a_quiet_in_reset: assert property (@(posedge clk) reset |=> !valid_out)
    else begin
      $error("valid_out high after a reset cycle");
      err_count++;
    end

  // No run longer than one result per output channel
  a_run_bounded: assert property (@(posedge clk) disable iff (reset)
    valid_out |-> run_len < C_OUT)
    else begin
      $error("valid_out run longer than the output channel count");
      err_count++;
    end

  a_run_full: assert property (@(posedge clk) disable iff (reset)
    $fell(valid_out) |-> run_len == C_OUT)
    else begin
      $error("valid_out run shorter than the output channel count");
      err_count++;
    end

  // Three edges of pipeline show as a rise at the fourth sample
  a_out_latency: assert property (@(posedge clk) disable iff (reset)
    last_in |-> ##4 $rose(valid_out))
    else begin
      $error("valid_out did not rise three edges after the last channel");
      err_count++;
    end

endmodule

`default_nettype wire

/* dv/conv1x1_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "conv1x1_config.svh"

module conv1x1_tb;

  localparam int DATA_W     = `CONV_DATA_W;
  localparam int C_IN       = `CONV_C_IN;
  localparam int C_OUT      = `CONV_C_OUT;
  localparam int OUT_MAX    = 2 ** (DATA_W - 1) - 1;
  localparam int OUT_MIN    = -(2 ** (DATA_W - 1));
  localparam int WAIT_LIMIT = 500;

  typedef conv1x1_pkg::data_t pixel_t [C_IN];
  typedef conv1x1_pkg::data_t wtab_t [C_OUT][C_IN];
  typedef conv1x1_pkg::data_t result_t [C_OUT];

  logic              clk;
  logic              reset;
  logic              valid_in;
  logic [DATA_W-1:0] pxl_in;
  logic              weight_valid;
  logic [DATA_W-1:0] weight_in;
  logic              valid_out;
  logic [DATA_W-1:0] pxl_out;

  logic [31:0]        rng_state;
  wtab_t              cur_wt;
  conv1x1_pkg::data_t exp_q [$];
  int                 out_count;

  conv1x1_top DUT (
    .clk          (clk),
    .reset        (reset),
    .valid_in     (valid_in),
    .pxl_in       (pxl_in),
    .weight_valid (weight_valid),
    .weight_in    (weight_in),
    .valid_out    (valid_out),
    .pxl_out      (pxl_out)
  );

  bind conv1x1_top conv1x1_sva u_sva (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (valid_in),
    .valid_out (valid_out)
  );

  // 40 ns period
  always #20 clk = ~clk;

  //////////////////////////////
  // Reference and random source
  //////////////////////////////

  // Saturate(sum(value * weight) >>> shift) per output
  function automatic void ref_conv(input pixel_t px, input wtab_t wt, output result_t res);
    int sum;
    int q;
    for (int o = 0; o < C_OUT; o++) begin
      sum = 0;
      for (int c = 0; c < C_IN; c++) begin
        sum += int'(px[c]) * int'(wt[o][c]);
      end
      q = sum >>> `CONV_SHIFT;
      if (q > OUT_MAX) begin
        q = OUT_MAX;
      end else if (q < OUT_MIN) begin
        q = OUT_MIN;
      end
      res[o] = conv1x1_pkg::data_t'(q);
    end
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // Signed value from the top bits of the draw
  function automatic conv1x1_pkg::data_t rand_val(input int bits);
    int v;
    v = $signed(next_rand()) >>> (32 - bits);
    return conv1x1_pkg::data_t'(v);
  endfunction

  function automatic void rand_pixel(output pixel_t px);
    for (int c = 0; c < C_IN; c++) begin
      px[c] = rand_val(DATA_W);
    end
  endfunction

  function automatic void rand_table(input int bits, output wtab_t wt);
    for (int o = 0; o < C_OUT; o++) begin
      for (int c = 0; c < C_IN; c++) begin
        wt[o][c] = rand_val(bits);
      end
    end
  endfunction

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // One expected result per output beat in queue order
  always @(posedge clk) begin : compare
    logic [DATA_W-1:0] exp_byte;
    if (!reset && valid_out === 1'b1) begin
      if (exp_q.size() == 0) begin
        abort_run("valid_out was raised with no result pending");
      end else begin
        exp_byte = exp_q.pop_front();
        check_value("pxl_out", pxl_out, exp_byte);
        out_count++;
      end
    end
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  // One weight per cycle in output-major order
  task automatic load_weights(input wtab_t wt);
    cur_wt = wt;
    for (int o = 0; o < C_OUT; o++) begin
      for (int c = 0; c < C_IN; c++) begin
        @(posedge clk);
        weight_valid <= 1'b1;
        weight_in    <= wt[o][c];
      end
    end
    @(posedge clk);
    weight_valid <= 1'b0;
  endtask

  // Leaves valid_in high so the next pixel can follow directly
  task automatic send_pixel(input pixel_t px, input int max_gap);
    result_t res;
    int      gap;
    ref_conv(px, cur_wt, res);
    for (int o = 0; o < C_OUT; o++) begin
      exp_q.push_back(res[o]);
    end
    for (int c = 0; c < C_IN; c++) begin
      gap = (max_gap > 0) ? int'(next_rand() % (max_gap + 1)) : 0;
      repeat (gap) begin
        @(posedge clk);
        valid_in <= 1'b0;
      end
      @(posedge clk);
      valid_in <= 1'b1;
      pxl_in   <= px[c];
    end
  endtask

  task automatic end_stream();
    @(posedge clk);
    valid_in <= 1'b0;
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0) begin
      if (cycles == WAIT_LIMIT) begin
        abort_run("Timeout: the DUT stopped producing results before all were checked");
      end
      @(posedge clk);
      cycles++;
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : main
    pixel_t px;
    wtab_t  wt;
    clk          = 1'b0;
    reset        = 1'b1;
    valid_in     = 1'b0;
    pxl_in       = '0;
    weight_valid = 1'b0;
    weight_in    = '0;
    rng_state    = 32'he3845650;
    out_count    = 0;

    // Quiet output through reset and after it
    for (int i = 0; i < 16; i++) begin
      @(posedge clk);
      if (i > 0) begin
        check_value("valid_out", DATA_W'(valid_out), '0);
      end
    end
    reset <= 1'b0;
    repeat (20) begin
      @(posedge clk);
      check_value("valid_out", DATA_W'(valid_out), '0);
    end

    // Small random weights with gaps inside pixels
    rand_table(5, wt);
    load_weights(wt);
    repeat (6) begin
      rand_pixel(px);
      send_pixel(px, 3);
    end
    end_stream();
    wait_drained();

    // Back to back so the drain overlaps the next accumulation
    repeat (6) begin
      rand_pixel(px);
      send_pixel(px, 0);
    end
    end_stream();
    wait_drained();

    // Saturation corners per lane
    for (int o = 0; o < C_OUT; o++) begin
      for (int c = 0; c < C_IN; c++) begin
        case (o % 4)
          0: wt[o][c] = conv1x1_pkg::data_t'(OUT_MAX);
          1: wt[o][c] = conv1x1_pkg::data_t'(OUT_MIN);
          2: wt[o][c] = conv1x1_pkg::data_t'((c % 2 == 0) ? OUT_MAX : OUT_MIN);
          default: wt[o][c] = '0;
        endcase
      end
    end
    load_weights(wt);
    for (int k = 0; k < 3; k++) begin
      for (int c = 0; c < C_IN; c++) begin
        if (k == 0) begin
          px[c] = conv1x1_pkg::data_t'(OUT_MAX);
        end else if (k == 1) begin
          px[c] = conv1x1_pkg::data_t'(OUT_MIN);
        end else begin
          px[c] = conv1x1_pkg::data_t'((c % 2 == 0) ? OUT_MAX : OUT_MIN);
        end
      end
      send_pixel(px, 1);
    end
    end_stream();
    wait_drained();

    // Fresh table replaces the old one
    rand_table(6, wt);
    load_weights(wt);
    repeat (4) begin
      rand_pixel(px);
      send_pixel(px, 2);
    end
    end_stream();
    wait_drained();

    repeat (20) @(posedge clk);
    $display("%0d outputs checked", out_count);
    if (exp_q.size() != 0) begin
      abort_run("Results were still pending at the end of the run");
    end else if (DUT.u_sva.err_count != 0) begin
      abort_run("A timing assertion on the output stream failed during the run");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* hw/conv1x1_drain.sv */
`timescale 1ns/10ps
`default_nettype none

`include "conv1x1_config.svh"

module conv1x1_drain (
  input  logic                clk,
  input  logic                reset,
  conv1x1_lane_if.drain       lanes [`CONV_C_OUT],
  output logic                valid_out,
  output conv1x1_pkg::data_t  pxl_out
);

  localparam int LANE_W   = (`CONV_C_OUT > 1) ? $clog2(`CONV_C_OUT) : 1;
  localparam int DATA_MAX = 2 ** (`CONV_DATA_W - 1) - 1;
  localparam int DATA_MIN = -(2 ** (`CONV_DATA_W - 1));
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`CONV_C_OUT - 1);

  conv1x1_pkg::acc_t  lane_sum [`CONV_C_OUT];
  conv1x1_pkg::acc_t  bank     [`CONV_C_OUT];
  logic               capture;
  logic               busy;
  logic [LANE_W-1:0]  out_cnt;
  conv1x1_pkg::acc_t  shifted;
  conv1x1_pkg::data_t sat;

  // Gather sums from the lane bundles
  for (genvar g = 0; g < `CONV_C_OUT; g++) begin : g_collect
    assign lane_sum[g] = lanes[g].sum;
  end

  // All lanes pulse together, lane 0 speaks for them
  assign capture = lanes[0].sum_valid;

  //////////////////////////////
  // Holding bank
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (capture) begin
      bank <= lane_sum;
    end
  end

  // Walk the bank once per capture
  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      out_cnt   <= '0;
      valid_out <= 1'b0;
    end else begin
      valid_out <= busy;
      if (capture) begin
        // New pixel may land on the last output of the old one
        busy    <= 1'b1;
        out_cnt <= '0;
      end else if (busy) begin
        if (out_cnt == LAST_LANE) begin
          busy <= 1'b0;
        end else begin
          out_cnt <= out_cnt + 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // Requantize and saturate
  //////////////////////////////

  always_comb begin
    shifted = bank[out_cnt] >>> `CONV_SHIFT;
    if (shifted > DATA_MAX) begin
      sat = conv1x1_pkg::data_t'(DATA_MAX);
    end else if (shifted < DATA_MIN) begin
      sat = conv1x1_pkg::data_t'(DATA_MIN);
    end else begin
      sat = conv1x1_pkg::data_t'(shifted);
    end
  end

  always_ff @(posedge clk) begin
    if (busy) begin
      pxl_out <= sat;
    end
  end

endmodule

`default_nettype wire

/* hw/conv1x1_feeder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "conv1x1_config.svh"

module conv1x1_feeder (
  input  logic               clk,
  input  logic               reset,
  input  logic               valid_in,
  input  conv1x1_pkg::data_t pxl_in,
  input  logic               weight_valid,
  input  conv1x1_pkg::data_t weight_in,
  conv1x1_lane_if.feed       lanes [`CONV_C_OUT]
);

  localparam int LANE_W = (`CONV_C_OUT > 1) ? $clog2(`CONV_C_OUT) : 1;
  localparam conv1x1_pkg::cin_idx_t LAST_CHAN = conv1x1_pkg::cin_idx_t'(`CONV_C_IN - 1);
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(`CONV_C_OUT - 1);

  // Pixel side
  conv1x1_pkg::cin_idx_t chan_cnt;
  conv1x1_pkg::data_t    data_r;
  conv1x1_pkg::cin_idx_t chan_r;
  logic                  last_r;
  logic                  data_valid_r;

  // Weight side
  conv1x1_pkg::cin_idx_t  wt_addr_cnt;
  logic [LANE_W-1:0]      wt_lane_cnt;
  conv1x1_pkg::data_t     wt_r;
  conv1x1_pkg::cin_idx_t  wt_addr_r;
  logic [`CONV_C_OUT-1:0] wt_we_r;

  //////////////////////////////
  // Pixel stream
  //////////////////////////////

  // Channel position, wraps once per pixel
  always_ff @(posedge clk) begin
    if (reset) begin
      chan_cnt     <= '0;
      data_valid_r <= 1'b0;
    end else begin
      data_valid_r <= valid_in;
      if (valid_in) begin
        chan_cnt <= (chan_cnt == LAST_CHAN) ? '0 : chan_cnt + 1'b1;
      end
    end
  end

  // Value and tags, only looked at with data_valid
  always_ff @(posedge clk) begin
    if (valid_in) begin
      data_r <= pxl_in;
      chan_r <= chan_cnt;
      last_r <= (chan_cnt == LAST_CHAN);
    end
  end

  //////////////////////////////
  // Weight stream
  //////////////////////////////

  // Output-major walk: address inner, lane outer
  always_ff @(posedge clk) begin
    if (reset) begin
      wt_addr_cnt <= '0;
      wt_lane_cnt <= '0;
      wt_we_r     <= '0;
    end else begin
      wt_we_r <= '0;
      if (weight_valid) begin
        // One-hot enable for the addressed lane
        wt_we_r[wt_lane_cnt] <= 1'b1;
        if (wt_addr_cnt == LAST_CHAN) begin
          wt_addr_cnt <= '0;
          wt_lane_cnt <= (wt_lane_cnt == LAST_LANE) ? '0 : wt_lane_cnt + 1'b1;
        end else begin
          wt_addr_cnt <= wt_addr_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (weight_valid) begin
      wt_r      <= weight_in;
      wt_addr_r <= wt_addr_cnt;
    end
  end

  // Same value to every lane, own write enable each
  for (genvar g = 0; g < `CONV_C_OUT; g++) begin : g_bcast
    assign lanes[g].data       = data_r;
    assign lanes[g].data_valid = data_valid_r;
    assign lanes[g].chan       = chan_r;
    assign lanes[g].last       = last_r;
    assign lanes[g].wt         = wt_r;
    assign lanes[g].wt_addr    = wt_addr_r;
    assign lanes[g].wt_we      = wt_we_r[g];
  end

endmodule

`default_nettype wire

/* hw/conv1x1_lane_if.sv */
`timescale 1ns/10ps
`default_nettype none

// One instance per MAC lane
interface conv1x1_lane_if;

  // Broadcast channel value and its position
  conv1x1_pkg::data_t    data;
  logic                  data_valid;
  conv1x1_pkg::cin_idx_t chan;
  logic                  last;

  // Weight write, enabled for one lane only
  conv1x1_pkg::data_t    wt;
  logic                  wt_we;
  conv1x1_pkg::cin_idx_t wt_addr;

  // Lane result
  conv1x1_pkg::acc_t     sum;
  logic                  sum_valid;

  modport feed  (output data, data_valid, chan, last, wt, wt_we, wt_addr);

  modport lane  (input data, data_valid, chan, last, wt, wt_we, wt_addr,
                 output sum, sum_valid);

  modport drain (input sum, sum_valid);

endinterface

`default_nettype wire

/* hw/conv1x1_mac_lane.sv */
`timescale 1ns/10ps
`default_nettype none

`include "conv1x1_config.svh"

module conv1x1_mac_lane (
  input logic          clk,
  input logic          reset,
  conv1x1_lane_if.lane port
);

  // Weights of this output channel
  conv1x1_pkg::data_t weights [`CONV_C_IN];

  logic signed [2*`CONV_DATA_W-1:0] prod;
  conv1x1_pkg::acc_t                prod_ext;
  conv1x1_pkg::acc_t                acc;
  logic                             sum_valid_r;

  //////////////////////////////
  // Weight store
  //////////////////////////////

  // Feeder only enables the lane that owns the weight
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CONV_C_IN; i++) begin
        weights[i] <= '0;
      end
    end else if (port.wt_we) begin
      weights[port.wt_addr] <= port.wt;
    end
  end

  //////////////////////////////
  // Multiply-accumulate
  //////////////////////////////

  // Full-width signed product
  assign prod     = port.data * weights[port.chan];
  // Sign extension up to the accumulator
  assign prod_ext = conv1x1_pkg::acc_t'(prod);

  // Channel 0 starts a new pixel, so load instead of add
  always_ff @(posedge clk) begin
    if (port.data_valid) begin
      if (port.chan == '0) begin
        acc <= prod_ext;
      end else begin
        acc <= acc + prod_ext;
      end
    end
  end

  // One-cycle pulse after the final channel lands
  always_ff @(posedge clk) begin
    if (reset) begin
      sum_valid_r <= 1'b0;
    end else begin
      sum_valid_r <= port.data_valid & port.last;
    end
  end

  assign port.sum       = acc;
  assign port.sum_valid = sum_valid_r;

endmodule

`default_nettype wire

/* hw/conv1x1_pkg.sv */
`default_nettype none

`include "conv1x1_config.svh"

//////////////////////////////
// Shared types of the 1x1 conv layer
//////////////////////////////

package conv1x1_pkg;

  // Signed pixel, weight or output value
  typedef logic signed [`CONV_DATA_W-1:0] data_t;

  // Signed accumulator value
  typedef logic signed [`CONV_ACC_W-1:0] acc_t;

  // Input channel index, also the weight address inside a lane
  typedef logic [$clog2(`CONV_C_IN)-1:0] cin_idx_t;

endpackage

`default_nettype wire

/* hw/conv1x1_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "conv1x1_config.svh"

module conv1x1_top (
  input  logic                   clk,
  input  logic                   reset,
  // Pixel stream, CONV_C_IN values per pixel
  input  logic                   valid_in,
  input  logic [`CONV_DATA_W-1:0] pxl_in,
  // Weight stream, output-channel-major
  input  logic                   weight_valid,
  input  logic [`CONV_DATA_W-1:0] weight_in,
  // CONV_C_OUT results per pixel, back to back
  output logic                   valid_out,
  output logic [`CONV_DATA_W-1:0] pxl_out
);

  // One bundle per output channel
  conv1x1_lane_if lane_bus [`CONV_C_OUT] ();

  //////////////////////////////
  // Broadcast and weight routing
  //////////////////////////////

  conv1x1_feeder u_feeder (
    .clk          (clk),
    .reset        (reset),
    .valid_in     (valid_in),
    .pxl_in       (pxl_in),
    .weight_valid (weight_valid),
    .weight_in    (weight_in),
    .lanes        (lane_bus)
  );

  // MAC lanes, one per output channel
  for (genvar g = 0; g < `CONV_C_OUT; g++) begin : g_lane
    conv1x1_mac_lane u_lane (
      .clk   (clk),
      .reset (reset),
      .port  (lane_bus[g])
    );
  end

  //////////////////////////////
  // Result serializer
  //////////////////////////////

  conv1x1_drain u_drain (
    .clk       (clk),
    .reset     (reset),
    .lanes     (lane_bus),
    .valid_out (valid_out),
    .pxl_out   (pxl_out)
  );

endmodule

`default_nettype wire

/* include/conv1x1_config.svh */
`ifndef CONV1X1_CONFIG_SVH
`define CONV1X1_CONFIG_SVH

//////////////////////////////
// Layer sizes
//////////////////////////////

// Pixel, weight and output width
`define CONV_DATA_W 8
// Accumulator width, holds CONV_C_IN full products
`define CONV_ACC_W 20
// Input channels per pixel
`define CONV_C_IN 8
// Output channels, one MAC lane each
`define CONV_C_OUT 4

// Requantization right shift
`define CONV_SHIFT 4

`endif

/* vlog.f */
+incdir+include
hw/conv1x1_pkg.sv
hw/conv1x1_lane_if.sv
hw/conv1x1_feeder.sv
hw/conv1x1_mac_lane.sv
hw/conv1x1_drain.sv
hw/conv1x1_top.sv
dv/conv1x1_sva.sv
dv/conv1x1_tb.sv
